// File: flist.f
+incdir+common
+incdir+dv
common/mdu_pkg.sv
common/dispatch_if.sv
common/cdb_if.sv
intm_rs/intm_rs.sv
intm_rs/fu_mul.sv
logic/phys_regfile.sv
logic/intm_top.sv
dv/intm_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TB_TOP     := intm_tb
RTL_TOP    := intm_top
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := SIMULATION PASSED
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/intm_stim.svh
`ifndef INTM_STIM_SVH
`define INTM_STIM_SVH

typedef enum {K_DISP, K_WB, K_WAIT} row_kind_e;
typedef enum {CHK_NONE, CHK_IDLE, CHK_PENDING, CHK_FULL, CHK_DRAIN} wait_chk_e;

// one step of the stimulus table
// value holds the writeback data or the expected product
typedef struct packed {
    row_kind_e              kind;
    int                     test;
    mul_op_e                op;
    logic [`MDU_ROB_W-1:0]  rob;
    logic [PHY_TAG_W-1:0]   rd;
    logic [PHY_TAG_W-1:0]   rs1;
    logic                   v1;
    logic [PHY_TAG_W-1:0]   rs2;
    logic                   v2;
    logic [`MDU_XLEN-1:0]   value;
    int                     cycles;
    wait_chk_e              chk;
} row_t;

row_t                   table_rows [$];
logic [`MDU_XLEN-1:0]   model_regs [`MDU_PHY_REGS];
int                     cur_test;
integer                 seed;

// riscv m extension rules on 64 bit extended operands
function automatic logic [`MDU_XLEN-1:0] ref_product(input mul_op_e op,
                                                     input logic [`MDU_XLEN-1:0] a,
                                                     input logic [`MDU_XLEN-1:0] b);
    logic [2*`MDU_XLEN-1:0] a_ext;
    logic [2*`MDU_XLEN-1:0] b_ext;
    logic [2*`MDU_XLEN-1:0] prod;
    a_ext = {{`MDU_XLEN{a[`MDU_XLEN-1]}}, a};
    b_ext = {{`MDU_XLEN{b[`MDU_XLEN-1]}}, b};
    if (op == OP_MULHU) begin
        a_ext = {{`MDU_XLEN{1'b0}}, a};
    end
    if (op == OP_MULHU || op == OP_MULHSU) begin
        b_ext = {{`MDU_XLEN{1'b0}}, b};
    end
    prod = a_ext * b_ext;
    if (op == OP_MUL) begin
        return prod[`MDU_XLEN-1:0];
    end
    return prod[2*`MDU_XLEN-1:`MDU_XLEN];
endfunction

function automatic row_t new_row(input row_kind_e kind);
    row_t r;
    r      = '0;
    r.kind = kind;
    r.test = cur_test;
    return r;
endfunction

function automatic void add_writeback(input int tag, input logic [`MDU_XLEN-1:0] val);
    row_t r;
    r        = new_row(K_WB);
    r.rd     = tag[PHY_TAG_W-1:0];
    r.value  = val;
    model_regs[tag] = val;
    table_rows.push_back(r);
endfunction

// expected product from the modelled registers, rd takes it
function automatic void add_dispatch(input mul_op_e op, input int rob, input int rd,
                                     input int rs1, input logic v1,
                                     input int rs2, input logic v2);
    row_t r;
    r       = new_row(K_DISP);
    r.op    = op;
    r.rob   = rob[`MDU_ROB_W-1:0];
    r.rd    = rd[PHY_TAG_W-1:0];
    r.rs1   = rs1[PHY_TAG_W-1:0];
    r.v1    = v1;
    r.rs2   = rs2[PHY_TAG_W-1:0];
    r.v2    = v2;
    r.value = ref_product(op, model_regs[rs1], model_regs[rs2]);
    model_regs[rd] = r.value;
    table_rows.push_back(r);
endfunction

function automatic void add_wait(input int cycles, input wait_chk_e chk, input int rob);
    row_t r;
    r        = new_row(K_WAIT);
    r.cycles = cycles;
    r.chk    = chk;
    r.rob    = rob[`MDU_ROB_W-1:0];
    table_rows.push_back(r);
endfunction

// ----------------------------------------------------------------------------
// table contents
// writeback tags stay below 16, multiply results use 16 and up
// ----------------------------------------------------------------------------
function automatic void build_table();
    logic [`MDU_XLEN-1:0]   rnd;
    int                     s1;
    int                     s2;
    seed = 32'he0e9_a4c3;
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end

    cur_test = 0;
    add_wait(8, CHK_IDLE, 0);

    // extreme operands through every opcode
    cur_test = 1;
    add_writeback(1, 32'h8000_0000);
    add_writeback(2, 32'hffff_ffff);
    add_writeback(3, 32'h7fff_ffff);
    add_writeback(4, 32'h0001_2345);
    add_dispatch(OP_MUL,    0, 16, 1, 1'b1, 2, 1'b1);
    add_dispatch(OP_MUL,    1, 17, 3, 1'b1, 4, 1'b1);
    add_dispatch(OP_MULH,   2, 18, 1, 1'b1, 1, 1'b1);
    add_dispatch(OP_MULH,   3, 19, 2, 1'b1, 3, 1'b1);
    add_dispatch(OP_MULHSU, 4, 20, 1, 1'b1, 2, 1'b1);
    add_dispatch(OP_MULHSU, 5, 21, 2, 1'b1, 3, 1'b1);
    add_dispatch(OP_MULHU,  6, 22, 2, 1'b1, 2, 1'b1);
    add_dispatch(OP_MULHU,  7, 23, 1, 1'b1, 4, 1'b1);
    add_wait(0, CHK_DRAIN, 0);

    // tag 5 only arrives after the dispatch
    cur_test = 2;
    model_regs[5] = 32'hffff_fff3;
    add_dispatch(OP_MULH, 8, 24, 5, 1'b0, 3, 1'b1);
    add_wait(12, CHK_PENDING, 8);
    add_writeback(5, 32'hffff_fff3);
    add_wait(0, CHK_DRAIN, 0);

    cur_test = 3;
    add_dispatch(OP_MUL,    9,  25, 3,  1'b1, 4,  1'b1);
    add_dispatch(OP_MULHSU, 10, 26, 25, 1'b0, 2,  1'b1);
    add_dispatch(OP_MUL,    11, 27, 26, 1'b0, 26, 1'b0);
    add_wait(0, CHK_DRAIN, 0);

    // all eight entries wait on tag 6
    cur_test = 4;
    model_regs[6] = 32'h1234_5678;
    for (int i = 0; i < 8; i++) begin
        add_dispatch(mul_op_e'(2'(i)), 12 + i, 16 + i, 6, 1'b0, 1 + (i % 4), 1'b1);
    end
    add_wait(2, CHK_FULL, 0);
    add_writeback(6, 32'h1234_5678);
    add_wait(0, CHK_DRAIN, 0);

    // unready sources get woken by a rewrite of the same value
    cur_test = 5;
    for (int t = 7; t < 15; t++) begin
        rnd = $random(seed);
        add_writeback(t, rnd);
    end
    for (int i = 0; i < 32; i++) begin
        rnd = $random(seed);
        s1  = 7 + int'(rnd[2:0]);
        s2  = 7 + int'(rnd[5:3]);
        add_dispatch(mul_op_e'(rnd[7:6]), i, 16 + (i % 16), s1, rnd[8], s2, rnd[9]);
        if (!rnd[8]) begin
            add_writeback(s1, model_regs[s1]);
        end
        if (!rnd[9]) begin
            add_writeback(s2, model_regs[s2]);
        end
    end
    add_wait(0, CHK_DRAIN, 0);
    add_wait(10, CHK_NONE, 0);
endfunction

`endif

// File: dv/intm_tb.sv
`timescale 1ns/1ps
`include "mdu_settings.svh"

module intm_tb
    import mdu_pkg::*;
();

    localparam int ROB_N = 2 ** `MDU_ROB_W;

    logic                   clk;
    logic                   rst;
    logic                   disp_valid;
    logic                   disp_ready;
    mul_op_e                disp_opcode;
    logic [`MDU_ROB_W-1:0]  disp_rob_id;
    logic [PHY_TAG_W-1:0]   disp_rd_phy;
    logic [PHY_TAG_W-1:0]   disp_rs1_phy;
    logic                   disp_rs1_valid;
    logic [PHY_TAG_W-1:0]   disp_rs2_phy;
    logic                   disp_rs2_valid;
    logic                   wb_valid;
    logic [PHY_TAG_W-1:0]   wb_rd_phy;
    logic [`MDU_XLEN-1:0]   wb_value;
    logic                   res_valid;
    logic [`MDU_ROB_W-1:0]  res_rob_id;
    logic [PHY_TAG_W-1:0]   res_rd_phy;
    logic [`MDU_XLEN-1:0]   res_value;

    `include "intm_stim.svh"

    // scoreboard keyed by rob id
    logic                   pending [ROB_N];
    logic [`MDU_XLEN-1:0]   exp_value [ROB_N];
    logic [PHY_TAG_W-1:0]   exp_rd [ROB_N];
    int                     pending_count = 0;
    int                     checks = 0;
    int                     errors = 0;
    int                     results = 0;
    int                     base_results = 0;
    int                     base_errors = 0;
    int                     cycle_count = 0;
    int                     cycle_limit = 200;
    string                  test_names [6] = '{"reset state", "all opcodes", "late wakeup",
                                               "multiply chain", "full station",
                                               "random stream"};

    intm_top uut (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_ready     (disp_ready),
        .disp_opcode    (disp_opcode),
        .disp_rob_id    (disp_rob_id),
        .disp_rd_phy    (disp_rd_phy),
        .disp_rs1_phy   (disp_rs1_phy),
        .disp_rs1_valid (disp_rs1_valid),
        .disp_rs2_phy   (disp_rs2_phy),
        .disp_rs2_valid (disp_rs2_valid),
        .wb_valid       (wb_valid),
        .wb_rd_phy      (wb_rd_phy),
        .wb_value       (wb_value),
        .res_valid      (res_valid),
        .res_rob_id     (res_rob_id),
        .res_rd_phy     (res_rd_phy),
        .res_value      (res_value)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // drivers
    // ------------------------------------------------------------------------
    task automatic dispatch_uop(input row_t r);
        @(posedge clk);
        disp_valid     <= 1'b1;
        disp_opcode    <= r.op;
        disp_rob_id    <= r.rob;
        disp_rd_phy    <= r.rd;
        disp_rs1_phy   <= r.rs1;
        disp_rs1_valid <= r.v1;
        disp_rs2_phy   <= r.rs2;
        disp_rs2_valid <= r.v2;
        // ready is stable by the falling edge
        @(negedge clk);
        while (!disp_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        disp_valid       <= 1'b0;
        pending[r.rob]   = 1'b1;
        exp_value[r.rob] = r.value;
        exp_rd[r.rob]    = r.rd;
        pending_count++;
    endtask

    // lane 1 is valid for exactly one cycle
    task automatic drive_writeback(input row_t r);
        @(posedge clk);
        wb_valid  <= 1'b1;
        wb_rd_phy <= r.rd;
        wb_value  <= r.value;
        @(posedge clk);
        wb_valid  <= 1'b0;
    endtask

    task automatic wait_and_check(input row_t r);
        repeat (r.cycles) @(negedge clk);
        case (r.chk)
            CHK_IDLE: begin
                checks++;
                assert (disp_ready === 1'b1 && res_valid === 1'b0)
                    else begin
                        $display("CHECK FAILED at %0t: station not idle, disp_ready %b res_valid %b",
                                 $time, disp_ready, res_valid);
                        errors++;
                    end
            end
            CHK_PENDING: begin
                checks++;
                assert (pending[r.rob])
                    else begin
                        $display("CHECK FAILED at %0t: rob_id %0d done before its source",
                                 $time, r.rob);
                        errors++;
                    end
            end
            CHK_FULL: begin
                checks++;
                assert (disp_ready === 1'b0)
                    else begin
                        $display("CHECK FAILED at %0t: disp_ready high with eight waiting",
                                 $time);
                        errors++;
                    end
            end
            CHK_DRAIN: begin
                while (pending_count != 0) begin
                    @(negedge clk);
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic report_test(input int test);
        $display("test %0d %s: %0d results, %0d errors", test, test_names[test],
                 results - base_results, errors - base_errors);
        base_results = results;
        base_errors  = errors;
    endtask

    // ------------------------------------------------------------------------
    // result monitor, lane 0 sampled mid cycle
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            results++;
            checks++;
            assert (pending[res_rob_id] === 1'b1)
                else begin
                    $display("unexpected result at %0t: rob_id %0d has nothing outstanding",
                             $time, res_rob_id);
                    errors++;
                end
            if (pending[res_rob_id] === 1'b1) begin
                checks += 2;
                assert (res_value === exp_value[res_rob_id])
                    else begin
                        $display("CHECK FAILED at %0t: rob_id %0d value %h, expected %h",
                                 $time, res_rob_id, res_value, exp_value[res_rob_id]);
                        errors++;
                    end
                assert (res_rd_phy === exp_rd[res_rob_id])
                    else begin
                        $display("CHECK FAILED at %0t: rob_id %0d rd_phy %0d, expected %0d",
                                 $time, res_rob_id, res_rd_phy, exp_rd[res_rob_id]);
                        errors++;
                    end
                pending[res_rob_id] = 1'b0;
                pending_count--;
            end
        end
    end

    // run limit from the table length
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles with %0d results still outstanding",
                     cycle_count, pending_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        rst            = 1'b1;
        disp_valid     = 1'b0;
        disp_opcode    = OP_MUL;
        disp_rob_id    = '0;
        disp_rd_phy    = '0;
        disp_rs1_phy   = '0;
        disp_rs1_valid = 1'b0;
        disp_rs2_phy   = '0;
        disp_rs2_valid = 1'b0;
        wb_valid       = 1'b0;
        wb_rd_phy      = '0;
        wb_value       = '0;
        foreach (pending[i]) begin
            pending[i] = 1'b0;
        end
        build_table();
        cycle_limit = 40 * table_rows.size() + 200;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        foreach (table_rows[i]) begin
            case (table_rows[i].kind)
                K_DISP:  dispatch_uop(table_rows[i]);
                K_WB:    drive_writeback(table_rows[i]);
                default: wait_and_check(table_rows[i]);
            endcase
            if (i == table_rows.size() - 1 || table_rows[i + 1].test != table_rows[i].test) begin
                report_test(table_rows[i].test);
            end
        end

        $display("checks %0d, results %0d, errors %0d", checks, results, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: logic/intm_top.sv
`timescale 1ns/1ps
`include "mdu_settings.svh"

module intm_top
    import mdu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // dispatch from rename
    input  logic                    disp_valid,
    output logic                    disp_ready,
    input  mul_op_e                 disp_opcode,
    input  logic [`MDU_ROB_W-1:0]   disp_rob_id,
    input  logic [PHY_TAG_W-1:0]    disp_rd_phy,
    input  logic [PHY_TAG_W-1:0]    disp_rs1_phy,
    input  logic                    disp_rs1_valid,
    input  logic [PHY_TAG_W-1:0]    disp_rs2_phy,
    input  logic                    disp_rs2_valid,

    // external writeback, drives lane 1
    input  logic                    wb_valid,
    input  logic [PHY_TAG_W-1:0]    wb_rd_phy,
    input  logic [`MDU_XLEN-1:0]    wb_value,

    // multiply results, copy of lane 0
    output logic                    res_valid,
    output logic [`MDU_ROB_W-1:0]   res_rob_id,
    output logic [PHY_TAG_W-1:0]    res_rd_phy,
    output logic [`MDU_XLEN-1:0]    res_value
);

    dispatch_if disp_bus ();
    cdb_if      cdb_bus [`MDU_CDB_WIDTH] ();

    logic [PHY_TAG_W-1:0]   rd_tag1;
    logic [PHY_TAG_W-1:0]   rd_tag2;
    logic [`MDU_XLEN-1:0]   rd_val1;
    logic [`MDU_XLEN-1:0]   rd_val2;
    logic                   issue_valid;
    issue_reg_t             issue_reg;

    // ------------------------------------------------------------------------
    // port to bus mapping
    // ------------------------------------------------------------------------
    assign disp_bus.valid         = disp_valid;
    assign disp_bus.uop.opcode    = disp_opcode;
    assign disp_bus.uop.rob_id    = disp_rob_id;
    assign disp_bus.uop.rd_phy    = disp_rd_phy;
    assign disp_bus.uop.rs1_phy   = disp_rs1_phy;
    assign disp_bus.uop.rs1_valid = disp_rs1_valid;
    assign disp_bus.uop.rs2_phy   = disp_rs2_phy;
    assign disp_bus.uop.rs2_valid = disp_rs2_valid;
    assign disp_ready             = disp_bus.ready;

    assign cdb_bus[1].valid  = wb_valid;
    assign cdb_bus[1].rd_phy = wb_rd_phy;
    assign cdb_bus[1].value  = wb_value;

    assign res_valid  = cdb_bus[0].valid;
    assign res_rd_phy = cdb_bus[0].rd_phy;
    assign res_value  = cdb_bus[0].value;

    intm_rs u_rs (
        .clk         (clk),
        .rst         (rst),
        .disp        (disp_bus),
        .cdb         (cdb_bus),
        .rd_tag1     (rd_tag1),
        .rd_tag2     (rd_tag2),
        .rd_val1     (rd_val1),
        .rd_val2     (rd_val2),
        .issue_valid (issue_valid),
        .issue_reg   (issue_reg)
    );

    phys_regfile u_prf (
        .clk     (clk),
        .rst     (rst),
        .cdb     (cdb_bus),
        .rd_tag1 (rd_tag1),
        .rd_tag2 (rd_tag2),
        .rd_val1 (rd_val1),
        .rd_val2 (rd_val2)
    );

    fu_mul u_mul (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_reg   (issue_reg),
        .cdb_out     (cdb_bus[0]),
        .rob_id_out  (res_rob_id)
    );

endmodule

// File: logic/phys_regfile.sv
`timescale 1ns/1ps
`include "mdu_settings.svh"

module phys_regfile
    import mdu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    cdb_if.snoop                    cdb [`MDU_CDB_WIDTH],

    input  logic [PHY_TAG_W-1:0]    rd_tag1,
    input  logic [PHY_TAG_W-1:0]    rd_tag2,
    output logic [`MDU_XLEN-1:0]    rd_val1,
    output logic [`MDU_XLEN-1:0]    rd_val2
);

    localparam int LANES = `MDU_CDB_WIDTH;

    logic [`MDU_XLEN-1:0]               regs_q [`MDU_PHY_REGS];

    // write ports, one per lane
    logic [LANES-1:0]                   wr_en;
    logic [LANES-1:0][PHY_TAG_W-1:0]    wr_tag;
    logic [LANES-1:0][`MDU_XLEN-1:0]    wr_data;

    for (genvar k = 0; k < LANES; k++) begin : g_wr
        assign wr_en[k]   = cdb[k].valid;
        assign wr_tag[k]  = cdb[k].rd_phy;
        assign wr_data[k] = cdb[k].value;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `MDU_PHY_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (wr_en[k]) begin
                    regs_q[wr_tag[k]] <= wr_data[k];
                end
            end
        end
    end

    // read with bypass of this cycle's writes
    function automatic logic [`MDU_XLEN-1:0] read_port(input logic [PHY_TAG_W-1:0] tag);
        logic [`MDU_XLEN-1:0] val;
        val = regs_q[tag];
        for (int k = 0; k < LANES; k++) begin
            if (wr_en[k] && (wr_tag[k] == tag)) begin
                val = wr_data[k];
            end
        end
        return val;
    endfunction

    // storage and lane changes must also refresh the read data
    always_comb begin
        rd_val1 = read_port(rd_tag1);
        rd_val2 = read_port(rd_tag2);
    end

    // multiplier lane and external writeback never collide on one register
    for (genvar i = 0; i < LANES; i++) begin : g_chk_i
        for (genvar j = i + 1; j < LANES; j++) begin : g_chk_j
            assert property (@(posedge clk) disable iff (rst)
                (wr_en[i] && wr_en[j]) |-> (wr_tag[i] != wr_tag[j]))
                else $error("phys_regfile: two lanes write one register");
        end
    end

endmodule

// File: intm_rs/fu_mul.sv
`timescale 1ns/1ps
`include "mdu_settings.svh"

module fu_mul
    import mdu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    issue_valid,
    input  issue_reg_t              issue_reg,

    cdb_if.drive                    cdb_out,
    output logic [`MDU_ROB_W-1:0]   rob_id_out
);

    localparam int XLEN = `MDU_XLEN;

    // stage 1, extended operands
    logic                       s1_valid;
    mul_op_e                    s1_op;
    logic [`MDU_ROB_W-1:0]      s1_rob;
    logic [PHY_TAG_W-1:0]       s1_rd;
    logic signed [XLEN:0]       s1_a;
    logic signed [XLEN:0]       s1_b;

    // stage 2, full product
    logic                       s2_valid;
    mul_op_e                    s2_op;
    logic [`MDU_ROB_W-1:0]      s2_rob;
    logic [PHY_TAG_W-1:0]       s2_rd;
    logic signed [2*XLEN+1:0]   s2_prod;

    // stage 3, selected half
    logic                       s3_valid;
    logic [`MDU_ROB_W-1:0]      s3_rob;
    logic [PHY_TAG_W-1:0]       s3_rd;
    logic [XLEN-1:0]            s3_res;

    logic                       a_signed;
    logic                       b_signed;

    // mulhu is the only unsigned rs1, mulhsu and mulhu have unsigned rs2
    always_comb begin
        a_signed = (issue_reg.opcode != OP_MULHU);
        b_signed = (issue_reg.opcode == OP_MUL) || (issue_reg.opcode == OP_MULH);
    end

    // ------------------------------------------------------------------------
    // valid pipe
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // ------------------------------------------------------------------------
    // data pipe, only moves with a valid item
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1_op  <= issue_reg.opcode;
            s1_rob <= issue_reg.rob_id;
            s1_rd  <= issue_reg.rd_phy;
            s1_a   <= {a_signed & issue_reg.rs1_value[XLEN-1], issue_reg.rs1_value};
            s1_b   <= {b_signed & issue_reg.rs2_value[XLEN-1], issue_reg.rs2_value};
        end
        if (s1_valid) begin
            s2_op   <= s1_op;
            s2_rob  <= s1_rob;
            s2_rd   <= s1_rd;
            s2_prod <= s1_a * s1_b;
        end
        if (s2_valid) begin
            s3_rob <= s2_rob;
            s3_rd  <= s2_rd;
            // mul keeps the low word, all mulh forms the high word
            s3_res <= (s2_op == OP_MUL) ? s2_prod[XLEN-1:0] : s2_prod[2*XLEN-1:XLEN];
        end
    end

    // broadcast on lane 0
    assign cdb_out.valid  = s3_valid;
    assign cdb_out.rd_phy = s3_rd;
    assign cdb_out.value  = s3_res;
    assign rob_id_out     = s3_rob;

endmodule

// File: intm_rs/intm_rs.sv
`timescale 1ns/1ps
`include "mdu_settings.svh"

module intm_rs
    import mdu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    dispatch_if.rs                  disp,
    cdb_if.snoop                    cdb [`MDU_CDB_WIDTH],

    output logic [PHY_TAG_W-1:0]    rd_tag1,
    output logic [PHY_TAG_W-1:0]    rd_tag2,
    input  logic [`MDU_XLEN-1:0]    rd_val1,
    input  logic [`MDU_XLEN-1:0]    rd_val2,

    output logic                    issue_valid,
    output issue_reg_t              issue_reg
);

    localparam int DEPTH = `MDU_RS_DEPTH;
    localparam int LANES = `MDU_CDB_WIDTH;

    // flat copy of the snooped lanes
    logic [LANES-1:0]                   snoop_valid;
    logic [LANES-1:0][PHY_TAG_W-1:0]    snoop_tag;

    for (genvar k = 0; k < LANES; k++) begin : g_snoop
        assign snoop_valid[k] = cdb[k].valid;
        assign snoop_tag[k]   = cdb[k].rd_phy;
    end

    // any lane broadcasting this tag right now
    function automatic logic cdb_hit(
        input logic [PHY_TAG_W-1:0]             tag,
        input logic [LANES-1:0]                 valid,
        input logic [LANES-1:0][PHY_TAG_W-1:0]  tags
    );
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            if (valid[k] && (tags[k] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ------------------------------------------------------------------------
    // station storage
    // ------------------------------------------------------------------------
    uop_t                   entry_q [DEPTH];
    logic [DEPTH-1:0]       occupied;
    logic [RS_IDX_W-1:0]    top_q;

    logic                   free_found;
    logic                   push_en;
    logic [RS_IDX_W-1:0]    push_idx;
    logic                   issue_en;
    logic [RS_IDX_W-1:0]    issue_idx;

    // first free slot, searching from top
    always_comb begin
        logic [RS_IDX_W-1:0] slot;
        free_found = 1'b0;
        push_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            slot = top_q + RS_IDX_W'(i);
            if (!free_found && !occupied[slot]) begin
                free_found = 1'b1;
                push_idx   = slot;
            end
        end
    end

    assign disp.ready = free_found;
    assign push_en    = disp.valid && disp.ready;

    // oldest-first from top, wakeups this cycle count as ready
    always_comb begin
        logic [RS_IDX_W-1:0] slot;
        logic                src1_ok;
        logic                src2_ok;
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            slot    = top_q + RS_IDX_W'(i);
            src1_ok = entry_q[slot].rs1_valid
                   || cdb_hit(entry_q[slot].rs1_phy, snoop_valid, snoop_tag);
            src2_ok = entry_q[slot].rs2_valid
                   || cdb_hit(entry_q[slot].rs2_phy, snoop_valid, snoop_tag);
            if (!issue_en && occupied[slot] && src1_ok && src2_ok) begin
                issue_en  = 1'b1;
                issue_idx = slot;
            end
        end
    end

    // register file read for the selected entry
    assign rd_tag1 = entry_q[issue_idx].rs1_phy;
    assign rd_tag2 = entry_q[issue_idx].rs2_phy;

    // occupancy, rotation and issue valid
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied    <= '0;
            top_q       <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (push_en) begin
                occupied[push_idx] <= 1'b1;
            end
            if (issue_en) begin
                occupied[issue_idx] <= 1'b0;
                top_q               <= issue_idx + RS_IDX_W'(1);
            end
            issue_valid <= issue_en;
        end
    end

    // entry payload, wakeup flags and issue register
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (occupied[i]) begin
                if (cdb_hit(entry_q[i].rs1_phy, snoop_valid, snoop_tag)) begin
                    entry_q[i].rs1_valid <= 1'b1;
                end
                if (cdb_hit(entry_q[i].rs2_phy, snoop_valid, snoop_tag)) begin
                    entry_q[i].rs2_valid <= 1'b1;
                end
            end
        end
        if (push_en) begin
            entry_q[push_idx] <= disp.uop;
            // merge same-cycle wakeups so they are not lost
            entry_q[push_idx].rs1_valid <= disp.uop.rs1_valid
                || cdb_hit(disp.uop.rs1_phy, snoop_valid, snoop_tag);
            entry_q[push_idx].rs2_valid <= disp.uop.rs2_valid
                || cdb_hit(disp.uop.rs2_phy, snoop_valid, snoop_tag);
        end
        if (issue_en) begin
            issue_reg.opcode    <= entry_q[issue_idx].opcode;
            issue_reg.rob_id    <= entry_q[issue_idx].rob_id;
            issue_reg.rd_phy    <= entry_q[issue_idx].rd_phy;
            issue_reg.rs1_value <= rd_val1;
            issue_reg.rs2_value <= rd_val2;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // full with nothing leaving means no handshake next cycle
    assert property (@(posedge clk) disable iff (rst)
        (&occupied && !issue_en) |=> !(disp.valid && disp.ready))
        else $error("intm_rs: push into a full station");

    // issued slot was live, then freed and handed to the multiplier
    assert property (@(posedge clk) disable iff (rst)
        issue_en |=> issue_valid && $past(occupied[issue_idx])
                     && !occupied[$past(issue_idx)])
        else $error("intm_rs: issue from an empty slot");

endmodule

// File: common/cdb_if.sv
`timescale 1ns/1ps
`include "mdu_settings.svh"

interface cdb_if
    import mdu_pkg::*;
();

    logic                   valid;
    logic [PHY_TAG_W-1:0]   rd_phy;
    logic [`MDU_XLEN-1:0]   value;

    // result producer
    modport drive (output valid, output rd_phy, output value);

    // wakeup and writeback listeners
    modport snoop (input valid, input rd_phy, input value);

endinterface

// File: common/dispatch_if.sv
`timescale 1ns/1ps

interface dispatch_if
    import mdu_pkg::*;
();

    logic   valid;
    logic   ready;
    uop_t   uop;

    // front end side
    modport drv (
        output valid,
        output uop,
        input  ready
    );

    // station side
    modport rs (
        input  valid,
        input  uop,
        output ready
    );

endinterface

// File: common/mdu_pkg.sv
`include "mdu_settings.svh"

package mdu_pkg;

    // derived index widths
    localparam int PHY_TAG_W = $clog2(`MDU_PHY_REGS);
    localparam int RS_IDX_W  = $clog2(`MDU_RS_DEPTH);

    // ------------------------------------------------------------------------
    // multiply opcodes
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_MUL    = 2'b00,
        OP_MULH   = 2'b01,
        OP_MULHSU = 2'b10,
        OP_MULHU  = 2'b11
    } mul_op_e;

    // renamed micro-op, also the station entry layout
    typedef struct packed {
        mul_op_e                opcode;
        logic [`MDU_ROB_W-1:0]  rob_id;
        logic [PHY_TAG_W-1:0]   rd_phy;
        logic [PHY_TAG_W-1:0]   rs1_phy;
        logic                   rs1_valid;
        logic [PHY_TAG_W-1:0]   rs2_phy;
        logic                   rs2_valid;
    } uop_t;

    // ------------------------------------------------------------------------
    // issue register, operands already read
    // ------------------------------------------------------------------------
    typedef struct packed {
        mul_op_e                opcode;
        logic [`MDU_ROB_W-1:0]  rob_id;
        logic [PHY_TAG_W-1:0]   rd_phy;
        logic [`MDU_XLEN-1:0]   rs1_value;
        logic [`MDU_XLEN-1:0]   rs2_value;
    } issue_reg_t;

endpackage

// File: common/mdu_settings.svh
`ifndef MDU_SETTINGS_SVH
`define MDU_SETTINGS_SVH

// datapath width of the integer core
`define MDU_XLEN 32

// physical register file size, tags are log2 of this
`define MDU_PHY_REGS 32

// multiply reservation station entries
`define MDU_RS_DEPTH 8

// reorder buffer id bits
`define MDU_ROB_W 5

// number of common data bus lanes
`define MDU_CDB_WIDTH 2

`endif
